// File: verilog/busAckPkg.sv
// Bus termination package
// Cycle space encoding, upper address map and ROM wait counter width
// shared by the decoder, both terminators and the acknowledge merger

package busAckPkg;

    //////////////////////////////
    // Cycle space
    //////////////////////////////

    // Space of the open bus cycle
    typedef enum logic [1:0] {
        SPACE_NONE = 2'd0,
        SPACE_ROM  = 2'd1,
        SPACE_CIA  = 2'd2
    } spaceT;

    //////////////////////////////
    // Address map
    //////////////////////////////

    // Upper address bits looked at by the decoder
    localparam int ADDR_HI_W = 8;

    // Kickstart ROM page and CIA page
    localparam logic [ADDR_HI_W-1:0] ROM_PAGE = 8'hF8;
    localparam logic [ADDR_HI_W-1:0] CIA_PAGE = 8'hBF;

    // ROM wait counter, delays of 1 to 15 falling edges
    localparam int DELAY_W = 4;

endpackage

// File: verilog/cycleIf.sv
// Bus cycle link between the decoder, the terminators and the merger
// Start pulse, held cycle space and the two termination strobes

`timescale 1ns/1ps

interface cycleIf import busAckPkg::*; ();

    // One clock pulse when a mapped cycle opens
    logic  start;
    // Space of the open cycle, SPACE_NONE when idle
    spaceT space;
    // One clock termination strobes
    logic  romAck;
    logic  ciaAck;

    // Decoder opens cycles and closes them again on either acknowledge
    modport decode (output start, output space, input romAck, input ciaAck);

    // ROM wait state terminator
    modport rom (input start, input space, output romAck);

    // CIA clock qualified terminator
    modport cia (input start, input space, output ciaAck);

    // Acknowledge merger sees the whole cycle
    modport merge (input start, input space, input romAck, input ciaAck);

endinterface

// File: verilog/spaceDecoder.sv
// Bus cycle space decoder
// Classifies each TS by the upper address bits, opens one cycle at a time
// and drives the ROM enable for the ROM space

`timescale 1ns/1ps

module spaceDecoder import busAckPkg::*; (
    input  logic                 CLK40,
    input  logic                 nRESET,
    input  logic                 ts,
    input  logic [ADDR_HI_W-1:0] addrHi,
    output logic                 nROMEN,
    cycleIf.decode               cyc
);

    // Cycle open, waiting for its acknowledge
    logic  busy;
    // Space hit by the current address
    spaceT hitSpace;

    // Address compare against the page map
    always_comb begin
        if (addrHi == ROM_PAGE) begin
            hitSpace = SPACE_ROM;
        end else if (addrHi == CIA_PAGE) begin
            hitSpace = SPACE_CIA;
        end else begin
            hitSpace = SPACE_NONE;
        end
    end

    always_ff @(posedge CLK40 or negedge nRESET) begin
        if (!nRESET) begin
            busy      <= 1'b0;
            cyc.start <= 1'b0;
            cyc.space <= SPACE_NONE;
        end else begin
            cyc.start <= 1'b0;
            if (busy) begin
                // New TS ignored until the cycle terminates
                if (cyc.romAck || cyc.ciaAck) begin
                    busy      <= 1'b0;
                    cyc.space <= SPACE_NONE;
                end
            end else if (ts && (hitSpace != SPACE_NONE)) begin
                cyc.start <= 1'b1;
                cyc.space <= hitSpace;
                busy      <= 1'b1;
            end
            // Unmapped cycles fall through to the bus timeout
        end
    end

    // ROM enable follows the held space
    assign nROMEN = (cyc.space != SPACE_ROM);

endmodule

// File: verilog/romTerminator.sv
// ROM cycle terminator
// Holds the acknowledge off for romDelay falling edges after start
// so the ROM access time is met before TA

`timescale 1ns/1ps

module romTerminator import busAckPkg::*; #(
    parameter int romDelay = 3
) (
    input  logic CLK40,
    input  logic nRESET,
    cycleIf.rom  cyc
);

    // Terminal count of the wait counter
    localparam logic [DELAY_W-1:0] DELAY_END = DELAY_W'(romDelay);

    //////////////////////////////
    // Wait state counter
    //////////////////////////////

    // Zero means idle
    logic [DELAY_W-1:0] waitCnt;

    // Falling edge sees the start pulse mid period
    always_ff @(negedge CLK40 or negedge nRESET) begin
        if (!nRESET) begin
            waitCnt    <= '0;
            cyc.romAck <= 1'b0;
        end else begin
            // Strobe lasts a single period
            cyc.romAck <= 1'b0;
            if (waitCnt == '0) begin
                // Only ROM cycles load the counter
                if (cyc.start && (cyc.space == SPACE_ROM)) begin
                    waitCnt <= DELAY_W'(1);
                end
            end else if (waitCnt == DELAY_END) begin
                // Setup met, terminate and go idle
                cyc.romAck <= 1'b1;
                waitCnt    <= '0;
            end else begin
                waitCnt <= waitCnt + DELAY_W'(1);
            end
        end
    end

    // Note that romDelay of 1 acks on the edge after start

endmodule

// File: verilog/ciaTerminator.sv
// CIA cycle terminator
// Synchronizes the slow CIA clock and ends a CIA cycle only after
// that clock has been seen high and then low

`timescale 1ns/1ps

module ciaTerminator import busAckPkg::*; (
    input  logic CLK40,
    input  logic nRESET,
    input  logic clkCia,
    cycleIf.cia  cyc
);

    //////////////////////////////
    // CIA clock history
    //////////////////////////////

    // Two stage synchronizer, bit 1 is the older sample
    logic [1:0] ciaHist;

    always_ff @(negedge CLK40 or negedge nRESET) begin
        if (!nRESET) begin
            ciaHist <= 2'b00;
        end else begin
            ciaHist <= {ciaHist[0], clkCia};
        end
    end

    //////////////////////////////
    // Termination
    //////////////////////////////

    // CIA cycle waiting for the clock
    logic pending;
    // High phase seen since start
    logic armed;

    always_ff @(negedge CLK40 or negedge nRESET) begin
        if (!nRESET) begin
            pending    <= 1'b0;
            armed      <= 1'b0;
            cyc.ciaAck <= 1'b0;
        end else begin
            cyc.ciaAck <= 1'b0;
            if (cyc.start && (cyc.space == SPACE_CIA)) begin
                pending <= 1'b1;
            end
            if (pending && !armed && (ciaHist == 2'b11)) begin
                armed <= 1'b1;
            end else if (armed && (ciaHist == 2'b00)) begin
                // Falling CIA edge after a high phase, safe to end
                cyc.ciaAck <= 1'b1;
                pending    <= 1'b0;
                armed      <= 1'b0;
            end
        end
    end

endmodule

// File: verilog/ackMerger.sv
// Transfer acknowledge merger
// Forms nTA and nTBI from the terminator strobes and keeps the TA line
// driven high one clock past the acknowledge

`timescale 1ns/1ps

module ackMerger import busAckPkg::*; (
    input  logic  CLK40,
    input  logic  nRESET,
    cycleIf.merge cyc,
    output logic  nTA,
    output logic  taDrive,
    output logic  nTBI
);

    // Acknowledge from the terminator that owns the space
    logic ackHit;
    // TA asserted this clock
    logic taLow;
    // Drive high after TA so the next cycle cannot end early
    logic holdHigh;
    // Cycle started and not yet acknowledged
    logic cycleOpen;

    assign ackHit = (cyc.romAck && (cyc.space == SPACE_ROM)) ||
                    (cyc.ciaAck && (cyc.space == SPACE_CIA));

    always_ff @(posedge CLK40 or negedge nRESET) begin
        if (!nRESET) begin
            taLow     <= 1'b0;
            holdHigh  <= 1'b0;
            cycleOpen <= 1'b0;
        end else begin
            taLow    <= ackHit;
            holdHigh <= taLow;
            if (cyc.start) begin
                cycleOpen <= 1'b1;
            end else if (ackHit) begin
                cycleOpen <= 1'b0;
            end
        end
    end

    // Burst inhibited on every acknowledged cycle
    assign nTA     = ~taLow;
    assign nTBI    = nTA;
    assign taDrive = cyc.start | cycleOpen | taLow | holdHigh;

endmodule

// File: verilog/transferAckTop.sv
// Transfer acknowledge top level
// Space decoder, ROM and CIA terminators and the acknowledge merger
// joined through one bus cycle interface

`timescale 1ns/1ps

module transferAckTop import busAckPkg::*; #(
    parameter int romDelay = 3
) (
    input  logic                 CLK40,
    input  logic                 nRESET,
    input  logic                 TS,
    input  logic [ADDR_HI_W-1:0] addrHi,
    input  logic                 CLKCIA,
    output logic                 nROMEN,
    output logic                 nTA,
    output logic                 nTBI,
    output logic                 taDrive
);

    // Shared cycle link
    cycleIf cyc ();

    //////////////////////////////
    // Decode
    //////////////////////////////

    spaceDecoder uDecoder (
        .CLK40  (CLK40),
        .nRESET (nRESET),
        .ts     (TS),
        .addrHi (addrHi),
        .nROMEN (nROMEN),
        .cyc    (cyc.decode)
    );

    //////////////////////////////
    // Terminators
    //////////////////////////////

    romTerminator #(.romDelay(romDelay)) uRomTerm (
        .CLK40  (CLK40),
        .nRESET (nRESET),
        .cyc    (cyc.rom)
    );

    ciaTerminator uCiaTerm (.CLK40(CLK40), .nRESET(nRESET), .clkCia(CLKCIA), .cyc(cyc.cia));

    // TA, TBI and drive enable at the pins
    ackMerger uMerger (
        .CLK40 (CLK40), .nRESET (nRESET), .cyc (cyc.merge),
        .nTA (nTA), .taDrive (taDrive), .nTBI (nTBI)
    );

endmodule

// File: verification/transferAckAssertions.sv
// Termination protocol assertions
// Watch the acknowledge strobes from the merger and from the decoder

`timescale 1ns/1ps

module transferAckAssertions #(
    parameter bit checkDrive = 1'b1
) (
    input logic CLK40,
    input logic nRESET,
    input logic romAck,
    input logic ciaAck,
    input logic taDrive
);

    // Each strobe lasts one clock
    assert property (@(posedge CLK40) disable iff (!nRESET) romAck |=> !romAck)
        else $error("romAck held longer than one clock");
    assert property (@(posedge CLK40) disable iff (!nRESET) ciaAck |=> !ciaAck)
        else $error("ciaAck held longer than one clock");

    // Only one terminator answers a cycle
    assert property (@(posedge CLK40) disable iff (!nRESET) !(romAck && ciaAck))
        else $error("romAck and ciaAck high together");

    // TA line still driven in the hold clock that follows TA low
    if (checkDrive) begin : driveCheck
        assert property (@(posedge CLK40) disable iff (!nRESET)
                         (romAck || ciaAck) |=> ##1 taDrive)
            else $error("taDrive released right after the acknowledge");
    end

endmodule

bind ackMerger transferAckAssertions uAckAssert (
    .CLK40 (CLK40), .nRESET (nRESET), .romAck (cyc.romAck), .ciaAck (cyc.ciaAck),
    .taDrive (taDrive)
);

// Decoder side has no drive enable
bind spaceDecoder transferAckAssertions #(.checkDrive(1'b0)) uDecAssert (
    .CLK40 (CLK40), .nRESET (nRESET), .romAck (cyc.romAck), .ciaAck (cyc.ciaAck),
    .taDrive (1'b0)
);

// File: verification/transferAckTb.sv
// Transfer acknowledge testbench
// Runs ROM, CIA and unmapped bus cycles through the termination block
// and checks TA timing against a reference latency model

`timescale 1ns/1ps

module transferAckTb import busAckPkg::*; ();

    localparam int ROM_DELAY = 3;
    // Clocks allowed for any wait
    localparam int TIMEOUT   = 200;
    // CLKCIA half period in CLK40 clocks
    localparam int CIA_HALF  = 10;
    localparam logic [ADDR_HI_W-1:0] FREE_PAGE = 8'h40;
    localparam int CIA_PHASES [7] = '{0, 3, 7, 9, 10, 14, 19};

    logic                 CLK40;
    logic                 nRESET;
    logic                 TS;
    logic [ADDR_HI_W-1:0] addrHi;
    logic                 CLKCIA;
    logic                 nROMEN;
    logic                 nTA;
    logic                 nTBI;
    logic                 taDrive;

    int          ciaPhase;
    logic [31:0] lfsrState;
    string       curTest;
    int          testErrors;
    int          errorCount;
    int          checkCount;
    int          testCount;
    int          failedTests;
    int          ackCount;
    logic        lastNta;

    transferAckTop #(.romDelay(ROM_DELAY)) dut (
        .CLK40   (CLK40),
        .nRESET  (nRESET),
        .TS      (TS),
        .addrHi  (addrHi),
        .CLKCIA  (CLKCIA),
        .nROMEN  (nROMEN),
        .nTA     (nTA),
        .nTBI    (nTBI),
        .taDrive (taDrive)
    );

    initial begin
        CLK40 = 1'b0;
        forever #20 CLK40 = ~CLK40;
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////

    // Galois LFSR with taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    task automatic takeBits(input int n, output int value);
        int i;
        value = 0;
        for (i = 0; i < n; i++) begin
            value = value | (int'(lfsrState[0]) << i);
            lfsrState = lfsrNext(lfsrState);
        end
    endtask

    function automatic bit ciaLevel(input int phase);
        return (phase % (2 * CIA_HALF)) < CIA_HALF;
    endfunction

    // Expected clocks from TS sample to nTA low
    // Returns -1 when no acknowledge is due
    function automatic int expectedLatency(input spaceT sp, input int phase);
        bit armed;
        int k;
        armed = 1'b0;
        if (sp == SPACE_ROM) return ROM_DELAY + 1;
        if (sp == SPACE_NONE) return -1;
        // Falling edge k reads the CLKCIA levels driven after edges k-2 and k-1
        for (k = 1; k < TIMEOUT; k++) begin
            if (!armed && ciaLevel(phase + k - 1) && ciaLevel(phase + k)) begin
                armed = 1'b1;
            end else if (armed && !ciaLevel(phase + k - 1) && !ciaLevel(phase + k)) begin
                return k + 1;
            end
        end
        return -1;
    endfunction

    task automatic compareValue(input string testName, input string what,
                                input int expected, input int actual);
        checkCount++;
        if (expected != actual) begin
            $display("mismatch %s %s: expected %0d actual %0d",
                     testName, what, expected, actual);
            errorCount++;
            testErrors++;
        end
    endtask

    task automatic reportFailure(input string testName, input string text);
        $display("%s: %s", testName, text);
        errorCount++;
        testErrors++;
    endtask

    task automatic finishTest();
        testCount++;
        if (testErrors == 0) begin
            $display("test %s: ok", curTest);
        end else begin
            $display("test %s: failed with %0d errors", curTest, testErrors);
            failedTests++;
        end
        testErrors = 0;
    endtask

    // Inputs move 2 ns after the next rising edge
    task automatic tick();
        @(posedge CLK40);
        #2;
        ciaPhase = (ciaPhase + 1) % (2 * CIA_HALF);
        CLKCIA   = ciaLevel(ciaPhase);
    endtask

    //////////////////////////////
    // Bus cycle
    //////////////////////////////

    task automatic runCycle(input spaceT sp, input int phase);
        int  k;
        int  lat;
        int  expLat;
        int  extra;
        bit  romSeen;
        bit  driveSeen;
        bit  sawHigh;
        bit  sawFall;
        lat = -1;
        extra = 0;
        romSeen = 1'b0;
        driveSeen = 1'b0;
        sawHigh = 1'b0;
        sawFall = 1'b0;
        tick();
        // Line TS up with the requested CLKCIA phase
        for (k = 0; phase >= 0 && ciaPhase != phase && k < TIMEOUT; k++) begin
            tick();
        end
        if (phase >= 0 && ciaPhase != phase) begin
            reportFailure(curTest, "CLKCIA never reached the requested phase");
        end
        expLat = expectedLatency(sp, ciaPhase);
        TS     = 1'b1;
        addrHi = (sp == SPACE_ROM) ? ROM_PAGE : (sp == SPACE_CIA) ? CIA_PAGE : FREE_PAGE;
        // Pass k looks at the k-th rising edge after TS was sampled
        for (k = 0; k < TIMEOUT && lat < 0; k++) begin
            tick();
            TS     = 1'b0;
            addrHi = '0;
            sawFall = sawFall | (sawHigh & !CLKCIA);
            sawHigh = sawHigh | CLKCIA;
            romSeen = romSeen | !nROMEN;
            driveSeen = driveSeen | taDrive;
            if (!nTA) lat = k;
        end
        if (sp == SPACE_NONE) begin
            compareValue(curTest, "nTA latency", -1, lat);
            compareValue(curTest, "taDrive seen", 0, driveSeen);
            compareValue(curTest, "nROMEN low seen", 0, romSeen);
        end else if (lat < 0) begin
            reportFailure(curTest, "no transfer acknowledge within the timeout");
        end else begin
            // One clock of slack either way for edge alignment
            if (lat < expLat - 1 || lat > expLat + 1) begin
                compareValue(curTest, "nTA latency", expLat, lat);
            end
            compareValue(curTest, "nROMEN low seen", sp == SPACE_ROM, romSeen);
            if (sp == SPACE_CIA) compareValue(curTest, "CLKCIA high then low", 1, sawFall);
            tick();
            compareValue(curTest, "nTA width", 1, nTA);
            compareValue(curTest, "taDrive after nTA", 1, taDrive);
            for (k = 0; k < 3; k++) begin
                tick();
                extra += !nTA;
            end
            compareValue(curTest, "extra nTA", 0, extra);
            compareValue(curTest, "nROMEN after cycle", 1, nROMEN);
        end
    endtask

    // Pin checks every clock mid period
    always begin
        @(posedge CLK40);
        #10;
        if (nRESET) begin
            compareValue(curTest, "nTBI", nTA, nTBI);
            if (!nTA || !lastNta) compareValue(curTest, "taDrive around nTA", 1, taDrive);
            if (!nTA && lastNta) ackCount++;
        end
        lastNta = nTA;
    end

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin
        int    i;
        int    j;
        int    sel;
        int    gap;
        int    phase;
        int    predicted;
        int    ackBase;
        spaceT sp;
        {TS, addrHi, nRESET, ciaPhase, ackCount} = '0;
        {errorCount, checkCount, failedTests, testErrors} = '0;
        testCount = 0;
        CLKCIA    = 1'b1;
        lastNta   = 1'b1;
        lfsrState = 32'h3cbb6b60;
        curTest   = "reset state";
        repeat (2) tick();
        nRESET = 1'b1;
        compareValue(curTest, "nTA", 1, nTA);
        compareValue(curTest, "nTBI", 1, nTBI);
        compareValue(curTest, "nROMEN", 1, nROMEN);
        compareValue(curTest, "taDrive", 0, taDrive);
        finishTest();
        curTest = "rom cycle";
        runCycle(SPACE_ROM, -1);
        finishTest();
        for (i = 0; i < 7; i++) begin
            curTest = $sformatf("cia phase %0d", CIA_PHASES[i]);
            runCycle(SPACE_CIA, CIA_PHASES[i]);
            finishTest();
        end
        curTest = "unmapped";
        runCycle(SPACE_NONE, -1);
        finishTest();
        curTest   = "random sequence";
        predicted = 0;
        ackBase   = ackCount;
        for (i = 0; i < 40; i++) begin
            takeBits(2, sel);
            takeBits(3, gap);
            takeBits(5, phase);
            sp    = (sel == 0) ? SPACE_NONE : (sel == 1) ? SPACE_ROM : SPACE_CIA;
            phase = phase % (2 * CIA_HALF);
            for (j = 0; j < gap; j++) tick();
            if (expectedLatency(sp, phase) >= 0) predicted++;
            runCycle(sp, phase);
        end
        compareValue(curTest, "acknowledge count", predicted, ackCount - ackBase);
        finishTest();
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 testCount, failedTests, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: all.f
verilog/busAckPkg.sv
verilog/cycleIf.sv
verilog/spaceDecoder.sv
verilog/romTerminator.sv
verilog/ciaTerminator.sv
verilog/ackMerger.sv
verilog/transferAckTop.sv
verification/transferAckAssertions.sv
verification/transferAckTb.sv
